/* audio_delay_pkg.sv */
package audio_delay_pkg;

    localparam int byte_idx_w = 13;                // Byte index into the 8 KiB audio window
    localparam int word_idx_w = 11;                // Word index into the same window
    localparam int sample_w   = 8;                 // One microphone sample is one byte
    localparam int word_w     = 32;                // SRAM data word
    localparam int addr_w     = 32;                // SRAM byte address

    // First byte of the audio window in the SRAM address space
    localparam logic [addr_w-1:0] sram_base = 32'h3300_0000;

    // One SRAM data word, seen either as a whole or as four sample lanes
    typedef union packed {
        logic [word_w-1:0]              raw;       // Word as it crosses the SRAM bus
        logic [3:0][sample_w-1:0]       lanes;     // Lane 0 sits in bits 7..0
    } audio_word_u;

    // Everything the design drives towards the SRAM
    typedef struct packed {
        logic                           read;      // Read request level
        logic                           write;     // Write request level
        logic [addr_w-1:0]              addr;      // Byte address of the word
        audio_word_u                    wdata;     // Full word to store
    } mem_req_t;

    // Everything the SRAM drives back
    typedef struct packed {
        logic                           busy;      // High while an access is in progress
        audio_word_u                    rdata;     // Valid from the cycle busy drops
    } mem_rsp_t;

    // Command sequencer states, also used as the strobe into both requesters
    typedef enum logic [1:0] {
        seq_idle  = 2'd0,                          // Waiting for record or search
        seq_read  = 2'd1,                          // One cycle that starts a search
        seq_write = 2'd2,                          // One cycle that stores a sample
        seq_busy  = 2'd3                           // Waiting for the requesters to finish
    } seq_state_e;

endpackage

/* mem_sequencer.sv */
`timescale 1ns/1ps

module mem_sequencer import audio_delay_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       record,           // Sample strobe from the effect side
    input  logic       search,           // Lookup strobe from the effect side
    input  logic       write_pending,    // Packer still holds the SRAM port
    input  logic       read_pending,     // Reader still holds the SRAM port
    output seq_state_e state
);

    seq_state_e state_next;              // Next-state value from the decoder below
    logic       bus_owned;               // Either requester still has an access open

    // The port is free only once both requesters have dropped their levels
    assign bus_owned = write_pending || read_pending;

    always_comb begin
        state_next = state;              // Hold by default
        case (state)
            seq_idle: begin
                // Commands are honoured here only, and a recording beats a search
                if (record) begin
                    state_next = seq_write;
                end else if (search) begin
                    state_next = seq_read;
                end
            end
            seq_write: begin
                state_next = seq_busy;   // Write step lasts exactly one cycle
            end
            seq_read: begin
                state_next = seq_busy;   // Read step lasts exactly one cycle
            end
            seq_busy: begin
                if (!bus_owned) begin
                    state_next = seq_idle;   // Nothing outstanding so accept again
                end
            end
            default: begin
                state_next = seq_idle;   // Unreachable with a 2-bit encoding
            end
        endcase
    end

    // Strobes seen outside idle fall through without effect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= seq_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* sample_packer.sv */
`timescale 1ns/1ps

module sample_packer import audio_delay_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  seq_state_e            state,        // Sequencer state used as the record strobe
    input  logic [sample_w-1:0]   mic_sample,   // Byte to store on a record step
    input  logic                  mem_busy,     // SRAM busy level
    output logic [byte_idx_w-1:0] write_ptr,    // Next byte position to be filled
    output logic                  write,        // Write request level and pending flag
    output logic [word_idx_w-1:0] write_addr,   // Word index of the pending write
    output audio_word_u           wdata         // Word handed to the SRAM
);

    logic [1:0]  lane;                          // Lane the incoming byte lands in
    audio_word_u pack_word;                     // Word under assembly
    audio_word_u pack_next;                     // Assembly word with the new byte merged
    logic        seen_busy;                     // SRAM has acknowledged the current write
    logic        write_done;                    // Completion cycle of the current write

    assign lane       = write_ptr[1:0];
    assign write_done = write && seen_busy && !mem_busy;

    // Merge the new byte so a lane 3 step can hand over the whole word at once
    always_comb begin
        pack_next             = pack_word;
        pack_next.lanes[lane] = mic_sample;
    end

    // Data path only moves on a record step
    always_ff @(posedge clk) begin
        if (state == seq_write) begin
            pack_word <= pack_next;
            if (lane == 2'd3) begin
                wdata      <= pack_next;                        // Freeze the full word
                write_addr <= write_ptr[byte_idx_w-1:2];        // And the word it belongs to
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            write_ptr <= '0;
            write     <= 1'b0;
            seen_busy <= 1'b0;
        end else begin
            if (state == seq_write) begin
                write_ptr <= write_ptr + 1'b1;                  // Wraps at 8192 bytes
            end
            // One write per four samples, held until the SRAM has finished it
            if (state == seq_write && lane == 2'd3) begin
                write <= 1'b1;
            end else if (write_done) begin
                write <= 1'b0;
            end
            // Busy may lag the request by a cycle so remember it was seen
            if (write_done) begin
                seen_busy <= 1'b0;
            end else if (write && mem_busy) begin
                seen_busy <= 1'b1;
            end
        end
    end

endmodule

/* delay_reader.sv */
`timescale 1ns/1ps

module delay_reader import audio_delay_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  seq_state_e            state,           // Sequencer state used as the search strobe
    input  logic [byte_idx_w-1:0] offset,          // Byte distance ahead of the write pointer
    input  logic [byte_idx_w-1:0] write_ptr,       // Packer's byte pointer
    input  logic                  write,           // Packer's write request level
    input  logic [word_idx_w-1:0] write_addr,      // Word the packer is writing
    input  mem_rsp_t              mem_rsp,         // SRAM response
    output logic                  read,            // Read request level and pending flag
    output logic [word_idx_w-1:0] read_addr,       // Word index of the search
    output logic [sample_w-1:0]   delayed_sample   // Byte found by the last search
);

    logic [byte_idx_w-1:0] read_idx;               // Byte index of the search
    logic [1:0]            read_lane;              // Lane of that byte inside its word
    audio_word_u           cache_word;             // Last word fetched from SRAM
    logic [word_idx_w-1:0] cache_addr;             // Word index of the cached word
    logic                  cache_valid;            // Cached word still matches SRAM
    logic                  cache_hit;              // Search lands in the cached word
    logic                  seen_busy;              // SRAM has acknowledged the current read
    logic                  read_done;              // Completion cycle of the current read

    assign read_addr = read_idx[byte_idx_w-1:2];
    assign read_lane = read_idx[1:0];              // Lane follows the search, not the pointer
    assign cache_hit = cache_valid && (cache_addr == read_addr);
    assign read_done = read && seen_busy && !mem_rsp.busy;

    // Tracks the pointer while idle so the value at the accepting edge is kept
    always_ff @(posedge clk) begin
        if (state == seq_idle) begin
            read_idx <= write_ptr + offset;        // Thirteen bits wrap modulo 8192
        end
    end

    always_ff @(posedge clk) begin
        if (read_done) begin
            cache_word <= mem_rsp.rdata;
            cache_addr <= read_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read           <= 1'b0;
            seen_busy      <= 1'b0;
            cache_valid    <= 1'b0;
            delayed_sample <= '0;
        end else begin
            // Only a miss goes out to the SRAM
            if (state == seq_read && !cache_hit) begin
                read <= 1'b1;
            end else if (read_done) begin
                read <= 1'b0;
            end
            if (read_done) begin
                seen_busy <= 1'b0;
            end else if (read && mem_rsp.busy) begin
                seen_busy <= 1'b1;
            end
            // A write to the cached word makes the copy stale
            if (read_done) begin
                cache_valid <= 1'b1;
            end else if (write && write_addr == cache_addr) begin
                cache_valid <= 1'b0;
            end
            // A hit answers straight away and a miss answers on completion
            if (state == seq_read && cache_hit) begin
                delayed_sample <= cache_word.lanes[read_lane];
            end else if (read_done) begin
                delayed_sample <= mem_rsp.rdata.lanes[read_lane];
            end
        end
    end

endmodule

/* audio_delay_top.sv */
`timescale 1ns/1ps

module audio_delay_top import audio_delay_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  record,          // Store mic_sample
    input  logic [sample_w-1:0]   mic_sample,
    input  logic                  search,          // Look up the byte at pointer plus offset
    input  logic [byte_idx_w-1:0] offset,
    input  mem_rsp_t              mem_rsp,         // From the external SRAM
    output mem_req_t              mem_req,         // To the external SRAM
    output logic [sample_w-1:0]   delayed_sample
);

    seq_state_e            state;                  // Shared command strobe
    logic [byte_idx_w-1:0] write_ptr;
    logic                  write;
    logic [word_idx_w-1:0] write_addr;
    audio_word_u           wdata;
    logic                  read;
    logic [word_idx_w-1:0] read_addr;
    logic [word_idx_w-1:0] word_sel;               // Word of whichever requester is active

    mem_sequencer seq_i (
        .clk           (clk),
        .rst           (rst),
        .record        (record),
        .search        (search),
        .write_pending (write),
        .read_pending  (read),
        .state         (state)
    );

    sample_packer packer_i (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .mic_sample (mic_sample),
        .mem_busy   (mem_rsp.busy),
        .write_ptr  (write_ptr),
        .write      (write),
        .write_addr (write_addr),
        .wdata      (wdata)
    );

    delay_reader reader_i (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .offset         (offset),
        .write_ptr      (write_ptr),
        .write          (write),
        .write_addr     (write_addr),
        .mem_rsp        (mem_rsp),
        .read           (read),
        .read_addr      (read_addr),
        .delayed_sample (delayed_sample)
    );

    // The sequencer never lets both requests overlap so one select is enough
    assign word_sel = write ? write_addr : read_addr;

    always_comb begin
        mem_req       = '0;                        // Quiet bus while nothing is requested
        mem_req.read  = read;
        mem_req.write = write;
        if (write || read) begin
            mem_req.addr = sram_base + {{(addr_w - word_idx_w - 2){1'b0}}, word_sel, 2'b00};
        end
        if (write) begin
            mem_req.wdata = wdata;
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;             // 10 ns period, first rising edge at 5 ns
    end

    initial begin
        rst = 1'b1;                        // Reset is active from time zero
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;                        // Released after three full cycles, between edges
    end

endmodule

/* tb_sram_model.sv */
`timescale 1ns/1ps

module tb_sram_model import audio_delay_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,              // Request levels from the DUT
    output mem_rsp_t mem_rsp,              // Busy level and read data back to the DUT
    output int       req_count,            // Requests taken so far
    output mem_req_t last_req              // Most recent request taken
);

    audio_word_u           mem [2**word_idx_w];  // Audio window, one entry per word
    logic [addr_w-1:0]     rel_addr;             // Byte address inside the window
    logic [word_idx_w-1:0] cur_word;             // Word of the access in progress
    logic [1:0]            wait_cnt;             // Busy cycles still to run
    logic                  served;               // Access done but request not yet dropped

    assign rel_addr = mem_req.addr - sram_base;

    // Odd multiplier so that every address bit reaches the pattern
    function automatic logic [word_w-1:0] fill_word(input logic [word_idx_w-1:0] w);
        return (32'(w) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**word_idx_w; i++) begin
                mem[i].raw <= fill_word(word_idx_w'(i));  // Known contents before any write
            end
            mem_rsp   <= '0;
            cur_word  <= '0;
            wait_cnt  <= '0;
            served    <= 1'b0;
            req_count <= 0;
            last_req  <= '0;
        end else if (mem_rsp.busy) begin
            if (wait_cnt == 2'd0) begin
                mem_rsp.busy <= 1'b0;                      // Third busy cycle is over
                served       <= 1'b1;
                if (last_req.read) begin
                    mem_rsp.rdata <= mem[cur_word];        // Valid as busy drops
                end
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else if (served) begin
            if (!(mem_req.read || mem_req.write)) begin
                served <= 1'b0;                            // Requester has let go of the port
            end
        end else if (mem_req.read || mem_req.write) begin
            mem_rsp.busy <= 1'b1;                          // Busy from the first edge it is seen
            wait_cnt     <= 2'd2;
            cur_word     <= rel_addr[word_idx_w+1:2];
            req_count    <= req_count + 1;
            last_req     <= mem_req;
            if (mem_req.write) begin
                mem[rel_addr[word_idx_w+1:2]] <= mem_req.wdata;
            end
        end
    end

endmodule

/* audio_delay_tb.sv */
`timescale 1ns/1ps

module audio_delay_tb import audio_delay_pkg::*; ();

    localparam int         max_rows  = 40;
    localparam logic [1:0] op_record = 2'd0;
    localparam logic [1:0] op_search = 2'd1;
    localparam logic [1:0] op_both   = 2'd2;   // Record and search in the same cycle

    typedef struct packed {
        logic [1:0]            op;
        logic [byte_idx_w-1:0] data;           // Sample in the low byte, or the offset
        logic [sample_w-1:0]   exp_sample;     // Delayed sample after the row
        logic                  exp_write;      // One write expected
        logic                  exp_read;       // One read expected
        logic [addr_w-1:0]     exp_addr;
        audio_word_u           exp_wdata;
        logic [byte_idx_w-1:0] exp_ptr;        // Write pointer after the row
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  record;
    logic                  search;
    logic [sample_w-1:0]   mic_sample;
    logic [byte_idx_w-1:0] offset;
    logic [sample_w-1:0]   delayed_sample;
    mem_req_t              mem_req;
    mem_rsp_t              mem_rsp;
    int                    req_count;
    mem_req_t              last_req;

    row_t                  rows [max_rows];
    int                    num_rows;
    int                    errors;
    int                    checks;
    int                    seed;
    int                    cycles = 0;
    int                    timeout_limit = max_rows * 12 + 50;

    logic [sample_w-1:0]   mirror_mem [2**byte_idx_w];  // Bytes as the SRAM holds them
    logic [byte_idx_w-1:0] mirror_ptr;
    audio_word_u           mirror_pack;                 // Word being filled lane by lane
    logic                  mirror_cache_valid;
    logic [word_idx_w-1:0] mirror_cache_word;
    logic [sample_w-1:0]   mirror_sample;               // Last sample the DUT should show

    tb_clock_gen clock_i (.clk(clk), .rst(rst));

    tb_sram_model sram_i (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .req_count (req_count),
        .last_req  (last_req)
    );

    audio_delay_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .record         (record),
        .mic_sample     (mic_sample),
        .search         (search),
        .offset         (offset),
        .mem_rsp        (mem_rsp),
        .mem_req        (mem_req),
        .delayed_sample (delayed_sample)
    );

    // Same power-up contents as the SRAM model
    function automatic logic [word_w-1:0] fill_word(input logic [word_idx_w-1:0] w);
        return (32'(w) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [byte_idx_w-1:0] random_value();
        return byte_idx_w'($random(seed));
    endfunction

    task automatic init_mirror();
        audio_word_u w;
        for (int i = 0; i < 2**word_idx_w; i++) begin
            w.raw = fill_word(word_idx_w'(i));
            for (int b = 0; b < 4; b++) begin
                mirror_mem[i * 4 + b] = w.lanes[b];    // Lane 0 is the lowest byte address
            end
        end
        mirror_ptr         = '0;
        mirror_pack        = '0;
        mirror_cache_valid = 1'b0;
        mirror_cache_word  = '0;
        mirror_sample      = '0;
    endtask

    // Appends one row and works out what the DUT must do for it
    task automatic add_row(input logic [1:0] op, input logic [byte_idx_w-1:0] data);
        row_t                  r;
        logic [byte_idx_w-1:0] idx;
        logic [word_idx_w-1:0] w;
        logic [1:0]            lane;
        r      = '0;
        r.op   = op;
        r.data = data;
        if (op == op_search) begin
            idx = mirror_ptr + data;                   // Wraps modulo 8192
            w   = idx[byte_idx_w-1:2];
            if (!(mirror_cache_valid && mirror_cache_word == w)) begin
                r.exp_read         = 1'b1;
                r.exp_addr         = sram_base + 32'(w) * 32'd4;
                mirror_cache_valid = 1'b1;
                mirror_cache_word  = w;
            end
            mirror_sample = mirror_mem[idx];
        end else begin
            lane = mirror_ptr[1:0];
            mirror_pack.lanes[lane] = data[sample_w-1:0];
            if (lane == 2'd3) begin
                w           = mirror_ptr[byte_idx_w-1:2];
                r.exp_write = 1'b1;
                r.exp_addr  = sram_base + 32'(w) * 32'd4;
                r.exp_wdata = mirror_pack;
                for (int b = 0; b < 4; b++) begin
                    mirror_mem[32'(w) * 4 + b] = mirror_pack.lanes[b];
                end
                if (mirror_cache_word == w) begin
                    mirror_cache_valid = 1'b0;         // Stored word replaces the cached copy
                end
            end
            mirror_ptr = mirror_ptr + 13'd1;
        end
        r.exp_sample   = mirror_sample;
        r.exp_ptr      = mirror_ptr;
        rows[num_rows] = r;
        num_rows++;
    endtask

    task automatic build_table();
        repeat (3) add_row(op_record, random_value());  // Word 0 still unfinished
        add_row(op_record, random_value());             // Completes word 0
        repeat (4) add_row(op_record, random_value());  // Word 1, pointer ends at 8
        add_row(op_search, 13'h1ffd);                   // Three back, miss on word 1
        add_row(op_search, 13'h1ffe);                   // Hit, other lane of word 1
        add_row(op_search, 13'h1ff8);                   // Eight back wraps to byte 0
        add_row(op_search, 13'h1ffb);                   // Hit on lane 3 of word 0
        add_row(op_search, 13'd100);                    // Untouched word, power-up data
        add_row(op_search, 13'd1);                      // Caches word 2 before it is written
        repeat (4) add_row(op_record, random_value());  // Writes word 2 and clears the cache
        add_row(op_search, 13'h1ffd);                   // Same byte again, now a miss
        add_row(op_search, 13'h1fff);                   // Hit on the fresh word
        add_row(op_both, random_value());               // Search dropped, record kept
        add_row(op_both, random_value());
        add_row(op_record, random_value());
        add_row(op_both, random_value());               // Lane 3 so a write follows
        add_row(op_search, 13'h1ffc);
        repeat (6) add_row(op_search, random_value());
        add_row(op_search, 13'h1fff);                   // Most recent byte
    endtask

    task automatic compare(input string name, input int row, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED row %0d %s got %h expected %h", row, name, got, exp);
        end
    endtask

    task automatic apply_row(input int n);
        row_t r;
        int   count_before;
        int   new_reqs;
        int   exp_reqs;
        r            = rows[n];
        count_before = req_count;
        @(negedge clk);
        record     = (r.op != op_search);
        search     = (r.op != op_record);
        mic_sample = r.data[sample_w-1:0];
        offset     = r.data;
        @(negedge clk);
        record = 1'b0;                                  // Strobes last one edge
        search = 1'b0;
        repeat (2) @(negedge clk);
        while (mem_rsp.busy) @(negedge clk);
        @(negedge clk);
        new_reqs = req_count - count_before;
        exp_reqs = int'(r.exp_write) + int'(r.exp_read);
        compare("request count", n, 32'(new_reqs), 32'(exp_reqs));
        if (exp_reqs == 1 && new_reqs == 1) begin
            compare("mem_req.write", n, 32'(last_req.write), 32'(r.exp_write));
            compare("mem_req.read", n, 32'(last_req.read), 32'(r.exp_read));
            compare("mem_req.addr", n, last_req.addr, r.exp_addr);
            if (r.exp_write) begin
                compare("mem_req.wdata", n, last_req.wdata.raw, r.exp_wdata.raw);
            end
        end
        compare("delayed_sample", n, 32'(delayed_sample), 32'(r.exp_sample));
        compare("write_ptr", n, 32'(dut_i.write_ptr), 32'(r.exp_ptr));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout: the table did not finish within %0d cycles", timeout_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        seed       = 32'he9cbccf4;
        record     = 1'b0;
        search     = 1'b0;
        mic_sample = '0;
        offset     = '0;
        errors     = 0;
        checks     = 0;
        num_rows   = 0;
        init_mirror();
        build_table();
        timeout_limit = num_rows * 12 + 50;            // About eight cycles per row at most
        @(negedge rst);
        @(negedge clk);
        compare("reset mem_req.read", -1, 32'(mem_req.read), 32'd0);
        compare("reset mem_req.write", -1, 32'(mem_req.write), 32'd0);
        compare("reset delayed_sample", -1, 32'(delayed_sample), 32'd0);
        for (int n = 0; n < num_rows; n++) begin
            apply_row(n);
        end
        $display("Finished %0d rows with %0d checks and %0d errors", num_rows, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src.f */
audio_delay_pkg.sv
mem_sequencer.sv
sample_packer.sv
delay_reader.sv
audio_delay_top.sv
tb_clock_gen.sv
tb_sram_model.sv
audio_delay_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the audio delay line testbench with Verilator and runs it

rm -rf obj_dir sim.log

verilator --binary -Wno-fatal --top-module audio_delay_tb -f src.f -o audio_delay_sim \
    && ./obj_dir/audio_delay_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
